// File: cnn_layer.f
+incdir+common
common/cnn_ctrl_pkg.sv
common/cnn_data_pkg.sv
hw/im2col/zero_padding.sv
hw/im2col/im2col.sv
hw/patch_fifo.sv
hw/conv_mac.sv
hw/cnn_layer.sv
dv/cnn_layer_tb.sv

// File: common/cnn_ctrl_pkg.sv
`default_nettype none

`include "cnn_defs.svh"

package cnn_ctrl_pkg;

  // two built-in layers
  typedef logic layer_id_t;

  localparam int NUM_LAYERS = 2;

  // im2col walker states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    WALK  = 2'd1,
    DRAIN = 2'd2
  } col_state_t;

  typedef logic signed [`DATA_LEN-1:0] weight_t;

  // kernel[row][col]
  typedef weight_t [`KER_DIM-1:0][`KER_DIM-1:0] kernel_t;

  // layer 0 edge detector, layer 1 blur with negative corners
  localparam kernel_t ker_rom [NUM_LAYERS] = '{
    '{'{-8'sd1, -8'sd1, -8'sd1},
      '{-8'sd1,  8'sd8, -8'sd1},
      '{-8'sd1, -8'sd1, -8'sd1}},
    '{'{-8'sd1,  8'sd2, -8'sd1},
      '{ 8'sd2,  8'sd4,  8'sd2},
      '{-8'sd1,  8'sd2, -8'sd1}}
  };

  // per-layer bias, added after the third kernel row
  localparam weight_t bias_rom [NUM_LAYERS] = '{
    8'sd3,
    -8'sd5
  };

endpackage

`default_nettype wire

// File: common/cnn_data_pkg.sv
`default_nettype none

`include "cnn_defs.svh"

package cnn_data_pkg;

  import cnn_ctrl_pkg::*;

  typedef logic signed [`DATA_LEN-1:0] pixel_t;
  typedef logic signed [`ACC_LEN-1:0]  acc_t;

  // element r*IMG_DIM + c is row r, column c
  typedef pixel_t [`IMG_DIM*`IMG_DIM-1:0] frame_t;

  // same layout, PAD_DIM wide
  typedef pixel_t [`PAD_DIM*`PAD_DIM-1:0] pad_map_t;

  // win[row][col]
  typedef pixel_t [`KER_DIM-1:0][`KER_DIM-1:0] window_t;

  // output pixel index, {row, col}
  typedef logic [$clog2(`IMG_DIM*`IMG_DIM)-1:0] out_idx_t;

  // one buffer entry
  typedef struct packed {
    window_t   win;
    layer_id_t layer;
    out_idx_t  idx;
  } patch_t;

  typedef acc_t [`IMG_DIM*`IMG_DIM-1:0] result_frame_t;

endpackage

`default_nettype wire

// File: common/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// pixel and weight width
`define DATA_LEN 8

// input frame edge
`define IMG_DIM 4

// kernel edge
`define KER_DIM 3

// frame edge with one pixel of zero border on each side
`define PAD_DIM 6

// full-precision dot product plus bias
`define ACC_LEN 20

// window buffer entries
`define FIFO_DEPTH 4

`endif

// File: dv/cnn_layer_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_layer_tb import cnn_data_pkg::*, cnn_ctrl_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 16 * 3 + 10;

  logic          clk;
  logic          rst;
  logic          load;
  layer_id_t     layer;
  frame_t        d;
  logic          busy;
  logic          valid;
  result_frame_t q;

  integer        seed = 32'h020479c0;
  result_frame_t exp_q [$];
  int            loads_accepted = 0;
  int            valids_seen = 0;

  cnn_layer dut_i (
    .clk   (clk),
    .rst   (rst),
    .load  (load),
    .layer (layer),
    .d     (d),
    .busy  (busy),
    .valid (valid),
    .q     (q)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // pad, convolve, add bias; kernels written out per layer
  function automatic result_frame_t ref_conv(frame_t f, layer_id_t l);
    int            p [`PAD_DIM][`PAD_DIM];
    int            k [3][3];
    int            b;
    int            s;
    result_frame_t res;
    if (l == 1'b0) begin
      // edge detector
      k = '{'{-1, -1, -1}, '{-1, 8, -1}, '{-1, -1, -1}};
      b = 3;
    end else begin
      // blur, corners negative
      k = '{'{-1, 2, -1}, '{2, 4, 2}, '{-1, 2, -1}};
      b = -5;
    end
    p = '{default: 0};
    for (int r = 0; r < `IMG_DIM; r++) begin
      for (int c = 0; c < `IMG_DIM; c++) begin
        p[r + 1][c + 1] = int'(f[r * `IMG_DIM + c]);
      end
    end
    for (int r = 0; r < `IMG_DIM; r++) begin
      for (int c = 0; c < `IMG_DIM; c++) begin
        s = b;
        for (int i = 0; i < 3; i++) begin
          for (int j = 0; j < 3; j++) begin
            s = s + k[i][j] * p[r + i][c + j];
          end
        end
        res[r * `IMG_DIM + c] = acc_t'(s);
      end
    end
    return res;
  endfunction

  function automatic frame_t random_frame();
    frame_t f;
    for (int i = 0; i < `IMG_DIM * `IMG_DIM; i++) begin
      f[i] = pixel_t'($random(seed));
    end
    return f;
  endfunction

  function automatic frame_t fill_frame(pixel_t v);
    frame_t f;
    for (int i = 0; i < `IMG_DIM * `IMG_DIM; i++) begin
      f[i] = v;
    end
    return f;
  endfunction

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_level(string name, logic actual, logic expected);
    assert (actual === expected) else
      report_error($sformatf("Fail %0t %s expected %0b actual %0b", $time, name, expected, actual));
  endtask

  // polls valid at the falling edge, where outputs are settled
  task automatic wait_valid();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT_CYCLES && !seen; n++) begin
      @(negedge clk);
      seen = valid;
    end
    if (!seen) begin
      report_error($sformatf("timeout at %0t: valid never came after the load", $time));
    end
  endtask

  // single load pulse, then wait for its result
  task automatic run_frame(frame_t f, layer_id_t l);
    exp_q.push_back(ref_conv(f, l));
    loads_accepted++;
    @(posedge clk);
    d     <= f;
    layer <= l;
    load  <= 1'b1;
    @(posedge clk);
    load  <= 1'b0;
    @(negedge clk);
    check_level("busy", busy, 1'b1);
    wait_valid();
  endtask

  // second frame pulsed mid-flight must leave no trace
  task automatic ignored_load(frame_t fa, layer_id_t la, frame_t fb);
    exp_q.push_back(ref_conv(fa, la));
    loads_accepted++;
    @(posedge clk);
    d     <= fa;
    layer <= la;
    load  <= 1'b1;
    @(posedge clk);
    load  <= 1'b0;
    repeat (5) @(posedge clk);
    d     <= fb;
    layer <= ~la;
    load  <= 1'b1;
    @(posedge clk);
    load  <= 1'b0;
    wait_valid();
    // idle long enough for a stray frame to finish
    repeat (TIMEOUT_CYCLES + 5) @(posedge clk);
  endtask

  // load held high; second frame taken in the cycle busy falls
  task automatic back_to_back(frame_t fa, layer_id_t la, frame_t fb, layer_id_t lb);
    exp_q.push_back(ref_conv(fa, la));
    loads_accepted++;
    @(posedge clk);
    d     <= fa;
    layer <= la;
    load  <= 1'b1;
    @(posedge clk);
    d     <= fb;
    layer <= lb;
    wait_valid();
    check_level("busy", busy, 1'b0);
    exp_q.push_back(ref_conv(fb, lb));
    loads_accepted++;
    @(posedge clk);
    load  <= 1'b0;
    wait_valid();
  endtask

  // comparing process, one expected frame per valid pulse
  initial begin
    result_frame_t exp_r;
    forever begin
      @(negedge clk);
      if (valid) begin
        valids_seen++;
        if (exp_q.size() == 0) begin
          report_error($sformatf("valid pulse at %0t with no accepted load pending", $time));
        end else begin
          exp_r = exp_q.pop_front();
          for (int i = 0; i < `IMG_DIM * `IMG_DIM; i++) begin
            assert (q[i] === exp_r[i]) else
              report_error($sformatf("Fail %0t q[%0d] expected %0d actual %0d",
                                     $time, i, exp_r[i], q[i]));
          end
        end
      end
    end
  end

  initial begin
    frame_t corner;
    clk   = 1'b0;
    rst   = 1'b1;
    load  = 1'b0;
    layer = 1'b0;
    d     = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // quiet outputs after reset
    repeat (5) begin
      @(negedge clk);
      check_level("busy", busy, 1'b0);
      check_level("valid", valid, 1'b0);
      assert (q === '0) else
        report_error($sformatf("Fail %0t q expected 0 actual %0h", $time, q));
    end

    for (int n = 0; n < 20; n++) begin
      run_frame(random_frame(), 1'b0);
    end

    for (int n = 0; n < 40; n++) begin
      run_frame(random_frame(), layer_id_t'(n % 2 == 0));
    end

    // saturated pixels and a lone corner
    corner    = '0;
    corner[0] = 8'sd127;
    for (int l = 0; l < 2; l++) begin
      run_frame(fill_frame(8'sd127), layer_id_t'(l));
      run_frame(fill_frame(-8'sd128), layer_id_t'(l));
      run_frame(corner, layer_id_t'(l));
    end

    ignored_load(random_frame(), 1'b0, random_frame());
    ignored_load(random_frame(), 1'b1, fill_frame(-8'sd128));

    back_to_back(random_frame(), 1'b0, random_frame(), 1'b1);
    back_to_back(random_frame(), 1'b1, random_frame(), 1'b1);

    repeat (5) @(posedge clk);
    if (valids_seen == loads_accepted && exp_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("valid pulse count %0d does not match accepted loads %0d",
               valids_seen, loads_accepted);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: hw/cnn_layer.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_layer import cnn_data_pkg::*, cnn_ctrl_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            load,
  input  wire layer_id_t layer,
  input  wire frame_t    d,
  output logic           busy,
  output logic           valid,
  output result_frame_t  q
);

  // producer to buffer
  pad_map_t pad_map;
  logic     pad_ready;
  logic     push;
  patch_t   push_data;
  logic     full;

  // buffer to consumer
  logic     pop;
  patch_t   pop_data;
  logic     empty;

  // padded frame held for the walker
  zero_padding zero_padding_i (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .busy      (busy),
    .d         (d),
    .pad_map   (pad_map),
    .pad_ready (pad_ready)
  );

  // busy ends when the consumer stores the last result
  im2col im2col_i (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .layer      (layer),
    .pad_ready  (pad_ready),
    .pad_map    (pad_map),
    .full       (full),
    .frame_done (valid),
    .push       (push),
    .push_data  (push_data),
    .busy       (busy)
  );

  patch_fifo patch_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  conv_mac conv_mac_i (
    .clk      (clk),
    .rst      (rst),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .valid    (valid),
    .q        (q)
  );

endmodule

`default_nettype wire

// File: hw/conv_mac.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defs.svh"

module conv_mac import cnn_data_pkg::*, cnn_ctrl_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         empty,
  input  wire patch_t pop_data,
  output logic        pop,
  output logic        valid,
  output result_frame_t q
);

  logic [1:0] row_cnt;
  acc_t       sum_q;
  acc_t       row_sum;
  acc_t       sum_next;
  acc_t       bias;
  kernel_t    ker;
  logic       last_row;

  // kernel and bias follow the layer carried in the patch
  assign ker      = ker_rom[pop_data.layer];
  assign bias     = acc_t'(bias_rom[pop_data.layer]);
  assign last_row = (row_cnt == `KER_DIM - 1);
  // release the head after its third row
  assign pop      = ~empty & last_row;

  // three products of the current row
  always_comb begin
    row_sum = '0;
    for (int j = 0; j < `KER_DIM; j++) begin
      row_sum = row_sum + acc_t'(pop_data.win[row_cnt][j]) * acc_t'(ker[row_cnt][j]);
    end
  end

  // row 0 starts a fresh sum
  always_comb begin
    if (row_cnt == '0) begin
      sum_next = row_sum;
    end else begin
      sum_next = sum_q + row_sum;
    end
  end

  always_ff @(posedge clk) begin
    if (~empty) begin
      sum_q <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      row_cnt <= '0;
      valid   <= 1'b0;
      q       <= '0;
    end else begin
      valid <= 1'b0;
      if (~empty) begin
        if (last_row) begin
          row_cnt           <= '0;
          q[pop_data.idx]   <= sum_next + bias;
          // last output pixel completes the frame
          valid             <= (pop_data.idx == '1);
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/im2col/im2col.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defs.svh"

module im2col import cnn_data_pkg::*, cnn_ctrl_pkg::*; (
  input  wire            clk,
  input  wire            rst,
  input  wire            load,
  input  wire layer_id_t layer,
  input  wire            pad_ready,
  input  wire pad_map_t  pad_map,
  input  wire            full,
  input  wire            frame_done,
  output logic           push,
  output patch_t         push_data,
  output logic           busy
);

  col_state_t                   state;
  logic [$clog2(`IMG_DIM)-1:0]  row_cnt;
  logic [$clog2(`IMG_DIM)-1:0]  col_cnt;
  layer_id_t                    layer_q;
  logic                         busy_q;
  logic                         take;
  logic                         last_pos;

  assign take     = load & ~busy;
  // drops in the valid cycle so a new load can follow at once
  assign busy     = busy_q & ~frame_done;
  assign last_pos = (row_cnt == `IMG_DIM - 1) && (col_cnt == `IMG_DIM - 1);
  // stall on full buffer
  assign push     = (state == WALK) & ~full;

  // window top-left sits at (row, col) of the padded map
  always_comb begin
    push_data.layer = layer_q;
    push_data.idx   = {row_cnt, col_cnt};
    for (int i = 0; i < `KER_DIM; i++) begin
      for (int j = 0; j < `KER_DIM; j++) begin
        push_data.win[i][j] = pad_map[(row_cnt + i) * `PAD_DIM + col_cnt + j];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      layer_q <= layer;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      row_cnt <= '0;
      col_cnt <= '0;
      busy_q  <= 1'b0;
    end else begin
      // a new load wins over the old frame's done
      if (take) begin
        busy_q <= 1'b1;
      end else if (frame_done) begin
        busy_q <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (pad_ready) begin
            state   <= WALK;
            row_cnt <= '0;
            col_cnt <= '0;
          end
        end
        WALK: begin
          // row-major, one window per accepted push
          if (push) begin
            col_cnt <= col_cnt + 1'b1;
            if (col_cnt == `IMG_DIM - 1) begin
              row_cnt <= row_cnt + 1'b1;
            end
            if (last_pos) begin
              state <= DRAIN;
            end
          end
        end
        DRAIN: begin
          // wait for the consumer to land index 15
          if (frame_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/im2col/zero_padding.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defs.svh"

module zero_padding import cnn_data_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         load,
  input  wire         busy,
  input  wire frame_t d,
  output pad_map_t    pad_map,
  output logic        pad_ready
);

  pad_map_t map_next;
  logic     take;

  // loads during a frame are dropped
  assign take = load & ~busy;

  // border stays zero, frame goes one row and one column in
  always_comb begin
    map_next = '0;
    for (int r = 0; r < `IMG_DIM; r++) begin
      for (int c = 0; c < `IMG_DIM; c++) begin
        map_next[(r + 1) * `PAD_DIM + c + 1] = d[r * `IMG_DIM + c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pad_map <= map_next;
    end
  end

  // map is valid from the cycle after the load
  always_ff @(posedge clk) begin
    if (rst) begin
      pad_ready <= 1'b0;
    end else begin
      pad_ready <= take;
    end
  end

endmodule

`default_nettype wire

// File: hw/patch_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_defs.svh"

module patch_fifo import cnn_data_pkg::*; (
  input  wire         clk,
  input  wire         rst,
  input  wire         push,
  input  wire patch_t push_data,
  input  wire         pop,
  output patch_t      pop_data,
  output logic        full,
  output logic        empty
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  patch_t            mem [`FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign do_push  = push & ~full;
  assign do_pop   = pop & ~empty;
  assign full     = (count == CNT_W'(`FIFO_DEPTH));
  assign empty    = (count == '0);
  // head entry, read without a clock
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push with pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cnn_layer_tb -f cnn_layer.f -o cnn_layer_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cnn_layer_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0
